// File: verilog/st_sink_pkg.sv
// Shared widths, vector types and structs for the streaming sink.
// Compile this package before any module that imports it.

package st_sink_pkg;

   // ----------------------------------------------------------------------
   // beat widths
   // ----------------------------------------------------------------------
   localparam int symbol_w    = 8;
   localparam int num_symbols = 4;
   localparam int data_w      = symbol_w * num_symbols;
   localparam int channel_w   = 4;
   localparam int error_w     = 2;
   // enough to count the unused symbols of a word
   localparam int empty_w     = $clog2(num_symbols);
   // idle stamp, saturating
   localparam int idle_w      = 8;

   // ----------------------------------------------------------------------
   // vector types
   // ----------------------------------------------------------------------
   typedef logic [data_w-1:0]    st_data_t;
   typedef logic [channel_w-1:0] st_channel_t;
   typedef logic [error_w-1:0]   st_error_t;
   typedef logic [empty_w-1:0]   st_empty_t;
   typedef logic [idle_w-1:0]    idle_count_t;

   // ----------------------------------------------------------------------
   // one beat as seen on the sink pins, 42 bits
   // ----------------------------------------------------------------------
   typedef struct packed {
      logic        sop;
      logic        eop;
      st_channel_t channel;
      st_data_t    data;
      st_error_t   error;
      st_empty_t   empty;
   } st_beat_t;

   // stamped transaction as stored in the FIFO, 50 bits
   typedef struct packed {
      idle_count_t idles;
      st_beat_t    beat;
   } st_record_t;

endpackage

// File: verilog/ready_latency_line.sv
// Delay line for the advertised ready.
// ready_qualified says whether the source may put a beat on the bus
// in the current cycle, given the configured ready latency.

`timescale 1ns/1ns

module ready_latency_line #(
   parameter int ready_latency = 1
) (
   input  logic clk,
   input  logic reset,
   input  logic sink_ready,
   output logic ready_qualified
);

   generate
      if (ready_latency == 0) begin : g_bypass
         // zero latency, the current ready decides
         assign ready_qualified = sink_ready;
      end else begin : g_delay
         // stage i holds ready from i+1 cycles back
         logic [ready_latency-1:0] ready_pipe;

         always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
               ready_pipe <= '0;
            end else begin
               ready_pipe[0] <= sink_ready;
               for (int i = 1; i < ready_latency; i++) begin
                  ready_pipe[i] <= ready_pipe[i-1];
               end
            end
         end

         assign ready_qualified = ready_pipe[ready_latency-1];
      end
   endgenerate

endmodule

// File: verilog/beat_capture.sv
// Accepts beats from the streaming source and stamps each with the
// number of idle cycles since the previous accepted beat.
// The record goes to the FIFO in the same cycle the beat is taken.

`timescale 1ns/1ns

module beat_capture import st_sink_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       ready_qualified,
   input  logic       sink_valid,
   input  st_beat_t   sink_beat,
   output logic       wr_en,
   output st_record_t wr_record
);

   // ----------------------------------------------------------------------
   // beat qualification
   // ----------------------------------------------------------------------
   // valid without qualified ready is a protocol slip and is dropped
   logic accept;
   // an allowed cycle that carried nothing
   logic idle_cycle;

   assign accept     = sink_valid & ready_qualified;
   assign idle_cycle = ready_qualified & ~sink_valid;

   // ----------------------------------------------------------------------
   // idle counter
   // ----------------------------------------------------------------------
   idle_count_t idle_count;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         idle_count <= '0;
      end else if (accept) begin
         // the stamp leaves with this beat, start over
         idle_count <= '0;
      end else if (idle_cycle) begin
         // stick at the top value on long gaps
         if (idle_count != '1) begin
            idle_count <= idle_count + idle_count_t'(1);
         end
      end
      // cycles without qualified ready leave the count alone
   end

   // ----------------------------------------------------------------------
   // record build
   // ----------------------------------------------------------------------
   // written at the accepting edge, no extra register stage
   assign wr_en = accept;

   always_comb begin
      wr_record       = '0;
      wr_record.idles = idle_count;
      wr_record.beat  = sink_beat;
   end

endmodule

// File: verilog/record_fifo.sv
// Circular buffer of stamped records.
// The head shows combinationally on out_record while out_valid is high;
// a pop strobe removes it. count reports occupancy for back-pressure.

`timescale 1ns/1ns

module record_fifo import st_sink_pkg::*; #(
   parameter int fifo_depth = 8
) (
   input  logic                            clk,
   input  logic                            reset,
   input  logic                            wr_en,
   input  st_record_t                      wr_record,
   input  logic                            pop,
   output logic                            out_valid,
   output st_record_t                      out_record,
   output logic [$clog2(fifo_depth+1)-1:0] count
);

   localparam int addr_w  = (fifo_depth > 1) ? $clog2(fifo_depth) : 1;
   localparam int count_w = $clog2(fifo_depth + 1);

   typedef logic [addr_w-1:0] addr_t;

   // last slot index, for pointer wrap on any depth
   localparam addr_t last_addr = addr_t'(fifo_depth - 1);

   // ----------------------------------------------------------------------
   // storage and pointers
   // ----------------------------------------------------------------------
   st_record_t mem [fifo_depth];

   addr_t rd_ptr;
   addr_t wr_ptr;

   logic full;
   logic do_pop;
   logic do_write;

   assign out_valid = (count != '0);
   assign full      = (count == count_w'(fifo_depth));
   // pop on empty is ignored
   assign do_pop    = pop & out_valid;
   // a full FIFO still takes a write when the head leaves at the same edge
   assign do_write  = wr_en & (~full | do_pop);

   // head is read straight from the array
   assign out_record = mem[rd_ptr];

   // payload has no reset
   always_ff @(posedge clk) begin
      if (do_write) begin
         mem[wr_ptr] <= wr_record;
      end
   end

   // ----------------------------------------------------------------------
   // pointer and occupancy update
   // ----------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= (wr_ptr == last_addr) ? '0 : wr_ptr + addr_t'(1);
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == last_addr) ? '0 : rd_ptr + addr_t'(1);
         end
         // both at once leaves occupancy unchanged
         case ({do_write, do_pop})
            2'b10:   count <= count + count_w'(1);
            2'b01:   count <= count - count_w'(1);
            default: count <= count;
         endcase
      end
   end

endmodule

// File: verilog/st_sink_top.sv
// Streaming sink top level: ready latency line, beat capture and record FIFO.
// sink_ready drops on hold or when the FIFO has no room left for beats
// that may still arrive inside the ready latency window.

`timescale 1ns/1ns

module st_sink_top import st_sink_pkg::*; #(
   parameter int ready_latency = 1,
   parameter int fifo_depth    = 8
) (
   input  logic       clk,
   input  logic       reset,
   input  logic       sink_valid,
   input  st_beat_t   sink_beat,
   output logic       sink_ready,
   input  logic       hold,
   input  logic       pop,
   output logic       out_valid,
   output st_record_t out_record
);

   localparam int count_w = $clog2(fifo_depth + 1);

   // occupancy must stay below this for ready to be offered
   localparam logic [count_w-1:0] ready_limit =
      count_w'(fifo_depth - ready_latency - 1);

   // ----------------------------------------------------------------------
   // ready rule
   // ----------------------------------------------------------------------
   logic               ready_qualified;
   logic               wr_en;
   st_record_t         wr_record;
   logic [count_w-1:0] count;
   // low in reset and set on the first clock after it
   logic               run;

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         run <= 1'b0;
      end else begin
         run <= 1'b1;
      end
   end

   assign sink_ready = run & ~hold & (count < ready_limit);

   // ----------------------------------------------------------------------
   // blocks
   // ----------------------------------------------------------------------
   ready_latency_line #(.ready_latency(ready_latency)) u_ready_line (
      .clk(clk), .reset(reset),
      .sink_ready(sink_ready), .ready_qualified(ready_qualified)
   );

   beat_capture u_capture (
      .clk(clk), .reset(reset), .ready_qualified(ready_qualified),
      .sink_valid(sink_valid), .sink_beat(sink_beat),
      .wr_en(wr_en), .wr_record(wr_record)
   );

   record_fifo #(.fifo_depth(fifo_depth)) u_fifo (
      .clk(clk), .reset(reset), .wr_en(wr_en), .wr_record(wr_record),
      .pop(pop), .out_valid(out_valid), .out_record(out_record), .count(count)
   );

endmodule

// File: test/st_sink_tb_table.svh
// Stimulus table for the streaming sink testbench.
// Each row gives an optional pop on an empty FIFO, a gap of idle cycles, one beat,
// the hold level, an expected sink_ready level and whether to drain afterwards.
`ifndef ST_SINK_TB_TABLE_SVH
`define ST_SINK_TB_TABLE_SVH

// exp_ready of this value skips the ready check
localparam logic [1:0] no_chk = 2'd2;

typedef struct packed {
   logic [7:0] test;
   logic [9:0] gap;
   // offer the beat for one cycle whether or not ready qualifies it
   logic       offer_force;
   logic       rnd;
   logic       hold;
   logic       pop_empty;
   logic       drain;
   logic [1:0] exp_ready;
   st_beat_t   beat;
} row_t;

localparam int n_rows = 20;

// columns: test, gap, force, rnd, hold, pop_empty, drain, exp_ready,
//          beat {sop, eop, channel, data, error, empty}
localparam row_t rows [n_rows] = '{
   // test 2, back-to-back packet
   '{8'd2, 10'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b1, 1'b0, 4'd3, 32'h11223344, 2'd0, 2'd0}},
   '{8'd2, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b0, 1'b0, 4'd3, 32'h0, 2'd1, 2'd0}},
   '{8'd2, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b0, 1'b0, 4'd3, 32'h0, 2'd2, 2'd0}},
   '{8'd2, 10'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, no_chk,
     '{1'b0, 1'b1, 4'd3, 32'hdeadbe00, 2'd0, 2'd3}},
   // test 3, idle stamps and saturation
   '{8'd3, 10'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b1, 1'b0, 4'd1, 32'h1, 2'd0, 2'd0}},
   '{8'd3, 10'd3, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b0, 1'b0, 4'd1, 32'h2, 2'd0, 2'd0}},
   '{8'd3, 10'd10, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, no_chk,
     '{1'b0, 1'b0, 4'd1, 32'h0, 2'd0, 2'd0}},
   '{8'd3, 10'd300, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1, no_chk,
     '{1'b0, 1'b1, 4'd1, 32'h4, 2'd0, 2'd1}},
   // test 4, hold and the latency window
   '{8'd4, 10'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b1, 1'b0, 4'd5, 32'h50, 2'd0, 2'd0}},
   '{8'd4, 10'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0,
     '{1'b0, 1'b0, 4'd5, 32'h51, 2'd1, 2'd0}},
   '{8'd4, 10'd0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 2'd0,
     '{1'b0, 1'b0, 4'd5, 32'h52, 2'd0, 2'd0}},
   '{8'd4, 10'd2, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 2'd0,
     '{1'b0, 1'b1, 4'd5, 32'h53, 2'd0, 2'd2}},
   // test 5, occupancy back-pressure with depth 8 and latency 1
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b1, 1'b0, 4'd7, 32'h0, 2'd0, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b0, 1'b0, 4'd7, 32'h0, 2'd0, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b0, 1'b0, 4'd7, 32'h0, 2'd0, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b0, 1'b0, 4'd7, 32'h0, 2'd3, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b0, 1'b0, 4'd7, 32'h0, 2'd0, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 2'd1,
     '{1'b0, 1'b0, 4'd7, 32'h0, 2'd0, 2'd0}},
   '{8'd5, 10'd0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 2'd0,
     '{1'b0, 1'b1, 4'd7, 32'h0, 2'd0, 2'd1}},
   // test 6, pop on an empty FIFO first
   '{8'd6, 10'd0, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, no_chk,
     '{1'b1, 1'b1, 4'd9, 32'h0, 2'd2, 2'd3}}
};

`endif

// File: test/st_sink_tb.sv
// Testbench for the streaming sink top level.
// Applies the stimulus table with a source model that mirrors the ready
// latency, predicts idle stamps and checks every popped record in order.

`timescale 1ns/1ns

module st_sink_tb import st_sink_pkg::*; ();

   localparam int period        = 100;
   localparam int ready_latency = 1;
   localparam int fifo_depth    = 8;
   localparam int hist_idx      = (ready_latency > 0) ? ready_latency - 1 : 0;

   `include "st_sink_tb_table.svh"

   logic       clk;
   logic       reset;
   logic       sink_valid;
   st_beat_t   sink_beat;
   logic       sink_ready;
   logic       hold;
   logic       pop;
   logic       out_valid;
   st_record_t out_record;

   // source model state
   logic [3:0]  ready_hist;
   idle_count_t model_idle;
   st_record_t  ref_q [$];
   logic [15:0] lfsr_state;

   int errors;
   int errors_mark;
   int tests_run;
   int tests_failed;

   st_sink_top #(.ready_latency(ready_latency), .fifo_depth(fifo_depth)) u_dut (
      .clk(clk), .reset(reset), .sink_valid(sink_valid), .sink_beat(sink_beat),
      .sink_ready(sink_ready), .hold(hold), .pop(pop),
      .out_valid(out_valid), .out_record(out_record)
   );

   always #(period / 2) clk = ~clk;

   // ----------------------------------------------------------------------
   // random data from a 16 bit Fibonacci LFSR with taps 16 14 13 11
   // ----------------------------------------------------------------------
   function automatic logic lfsr_bit();
      logic fb;
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      return fb;
   endfunction

   function automatic st_data_t rand_word();
      st_data_t w;
      w = '0;
      for (int b = 0; b < data_w; b++) begin
         w = {w[data_w-2:0], lfsr_bit()};
      end
      return w;
   endfunction

   // ----------------------------------------------------------------------
   // one clock cycle of source and consumer
   // mode 0 no beat, 1 beat only when qualified, 2 beat regardless
   // ----------------------------------------------------------------------
   task automatic run_cycle(input int mode, input st_beat_t beat, input logic hold_v,
                            input logic pop_v, output logic accepted, output logic ready_now);
      logic       qual;
      st_record_t rec;
      @(negedge clk);
      hold = hold_v;
      pop  = pop_v;
      #1;
      ready_now = sink_ready;
      qual = (ready_latency == 0) ? ready_now : ready_hist[hist_idx];
      sink_valid = (mode == 2) || (mode == 1 && qual);
      sink_beat  = beat;
      #1;
      // head check before this edge's write lands
      if (pop_v) begin
         if (out_valid && ref_q.size() == 0) begin
            $display("at %0t ns: FIFO shows a record that was never accepted", $time);
            errors++;
         end else if (!out_valid && ref_q.size() > 0) begin
            $display("at %0t ns: stored record missing, out_valid is low", $time);
            errors++;
            void'(ref_q.pop_front());
         end else if (out_valid) begin
            rec = ref_q.pop_front();
            if (out_record !== rec) begin
               $display("CHECK FAILED at %0t ns: out_record expected %h got %h",
                        $time, rec, out_record);
               errors++;
            end
         end
      end
      // idle rule and acceptance as seen by the source
      accepted = sink_valid && qual;
      if (accepted) begin
         rec.idles = model_idle;
         rec.beat  = beat;
         ref_q.push_back(rec);
         model_idle = '0;
      end else if (qual && model_idle != 8'hff) begin
         model_idle = model_idle + 8'd1;
      end
      ready_hist = {ready_hist[2:0], ready_now};
   endtask

   task automatic report_test(input int t);
      tests_run++;
      if (errors > errors_mark) begin
         tests_failed++;
         $display("test %0d: FAILED with %0d errors", t, errors - errors_mark);
      end else begin
         $display("test %0d: passed", t);
      end
      errors_mark = errors;
   endtask

   // ----------------------------------------------------------------------
   // main sequence
   // ----------------------------------------------------------------------
   initial begin
      row_t     row;
      st_beat_t beat;
      logic     acc;
      logic     rdy;
      int       tries;
      clk = 1'b0;
      reset = 1'b1;
      sink_valid = 1'b0;
      sink_beat = '0;
      hold = 1'b0;
      pop = 1'b0;
      ready_hist = '0;
      model_idle = '0;
      lfsr_state = 16'd73;
      errors = 0;
      errors_mark = 0;
      tests_run = 0;
      tests_failed = 0;

      // test 1 checks the reset behavior
      for (int c = 0; c < 8; c++) begin
         @(negedge clk);
         if (sink_ready !== 1'b0) begin
            $display("CHECK FAILED at %0t ns: sink_ready expected 0 got %b", $time, sink_ready);
            errors++;
         end
         if (out_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t ns: out_valid expected 0 got %b", $time, out_valid);
            errors++;
         end
      end
      reset = 1'b0;
      tries = 0;
      rdy = 1'b0;
      while (!rdy && tries < 5) begin
         run_cycle(0, '0, 1'b0, 1'b0, acc, rdy);
         if (out_valid !== 1'b0) begin
            $display("CHECK FAILED at %0t ns: out_valid expected 0 got %b", $time, out_valid);
            errors++;
         end
         tries++;
      end
      if (!rdy) begin
         $display("at %0t ns: sink_ready never rose after reset", $time);
         errors++;
      end
      report_test(1);

      for (int i = 0; i < n_rows; i++) begin
         row = rows[i];
         beat = row.beat;
         if (row.rnd) begin
            beat.data = rand_word();
         end
         if (row.pop_empty) begin
            run_cycle(0, beat, row.hold, 1'b1, acc, rdy);
         end
         for (int g = 0; g < int'(row.gap); g++) begin
            run_cycle(0, beat, row.hold, 1'b0, acc, rdy);
         end
         if (row.offer_force) begin
            run_cycle(2, beat, row.hold, 1'b0, acc, rdy);
         end else begin
            tries = 0;
            acc = 1'b0;
            while (!acc && tries < 50) begin
               run_cycle(1, beat, row.hold, 1'b0, acc, rdy);
               tries++;
            end
            if (!acc) begin
               $display("at %0t ns: beat of row %0d was never accepted", $time, i);
               errors++;
            end
         end
         if (row.exp_ready != no_chk && rdy !== row.exp_ready[0]) begin
            $display("CHECK FAILED at %0t ns: sink_ready expected %b got %b",
                     $time, row.exp_ready[0], rdy);
            errors++;
         end
         if (row.drain) begin
            // one more pop after the last expected record catches a stray one
            while (ref_q.size() > 0 || out_valid) begin
               run_cycle(0, beat, 1'b0, 1'b1, acc, rdy);
            end
         end
         if (i == n_rows - 1 || rows[i+1].test != row.test) begin
            report_test(int'(row.test));
         end
      end

      $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

   // budget of 400 cycles per table row plus the reset phase
   initial begin
      #(period * (n_rows * 400 + 100));
      $display("watchdog: the run did not finish in time");
      $display("Some tests failed");
      $finish;
   end

endmodule

// File: all.f
+incdir+test
verilog/st_sink_pkg.sv
verilog/ready_latency_line.sv
verilog/beat_capture.sv
verilog/record_fifo.sv
verilog/st_sink_top.sv
test/st_sink_tb.sv

// File: Makefile
# Verilator build for the streaming sink.
# Override any variable on the command line, for example make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= st_sink_tb
RTL_TOP   ?= st_sink_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_TEXT ?= All tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
